// File: hw/frameBufPkg.sv
package frameBufPkg;

	localparam int dataWidth = 16;
	localparam int bufDepth = 8; // one cell always stays unused.
	localparam int addrWidth = 3;

	typedef logic [dataWidth-1:0] bufData;
	typedef logic [addrWidth-1:0] bufAddr;
	typedef logic [addrWidth-1:0] bufCount; // holds 0 to 7 committed words.

	localparam bufAddr memStartAddr = 3'd0;
	localparam bufAddr memEndAddr = 3'd7;

	typedef enum logic [1:0] {
		wrIdle,
		wrPush,
		wrWait,
		wrClose
	} writerState;

endpackage

// File: hw/bufferMemory.sv
module bufferMemory (
	input  logic clk,
	input  logic rst,
	input  logic wrRequest,
	input  frameBufPkg::bufAddr wrAddr,
	input  frameBufPkg::bufData wrData,
	output logic wrDone,
	input  logic rdRequest,
	input  frameBufPkg::bufAddr rdAddr,
	output frameBufPkg::bufData rdData
	,
	output logic rdDone
);
	import frameBufPkg::*;

	bufData mem [bufDepth];

	logic wrAccept;
	logic rdAccept;

	// a request is only taken while the matching done is low.
	assign wrAccept = wrRequest && !wrDone;
	assign rdAccept = rdRequest && !rdDone;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrDone <= 1'b0;
			rdDone <= 1'b0;
		end else begin
			wrDone <= wrAccept; // high for exactly one cycle.
			rdDone <= rdAccept;
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept) begin
			mem[wrAddr] <= wrData;
		end
	end

	// rdData holds the last word read until the next read is taken.
	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rdData <= mem[rdAddr];
		end
	end

endmodule

// File: hw/ringBuffer.sv
module ringBuffer (
	input  logic clk,
	input  logic rst,
	input  logic open,
	input  logic commit,
	input  logic rollback,
	input  logic pushRequest,
	input  frameBufPkg::bufData pushData,
	output logic pushDone,
	input  logic popRequest,
	output frameBufPkg::bufData popData,
	output logic popDone,
	output frameBufPkg::bufCount memUsed,
	output logic wrRequest,
	output frameBufPkg::bufAddr wrAddr,
	output frameBufPkg::bufData wrData,
	input  logic wrDone,
	output logic rdRequest,
	output frameBufPkg::bufAddr rdAddr,
	input  logic rdDone,
	input  frameBufPkg::bufData rdData
);
	import frameBufPkg::*;

	bufAddr wrPtr;
	bufAddr rdPtr;
	bufAddr cmPtr;
	bufAddr nextWrPtr;
	bufAddr nextRdPtr;
	bufAddr nextCmPtr;
	bufAddr wrPtrInc;
	bufAddr rdPtrInc;

	logic inTransFlag;
	logic inTrans;

	// open takes effect in its own cycle.
	assign inTrans = open || inTransFlag;

	assign wrRequest = pushRequest;
	assign wrAddr = wrPtr;
	assign wrData = pushData;

	assign rdAddr = rdPtr;
	assign rdRequest = popRequest && (memUsed != '0); // an empty buffer ignores pops.
	assign popData = rdData;

	// distance from the read pointer to the commit pointer around the window.
	always_comb begin
		if (cmPtr >= rdPtr) begin
			memUsed = bufCount'(cmPtr - rdPtr);
		end else begin
			memUsed = bufCount'(memEndAddr - memStartAddr + cmPtr - rdPtr + 1);
		end
	end

	always_comb begin
		if (wrPtr == memEndAddr) begin
			wrPtrInc = memStartAddr;
		end else begin
			wrPtrInc = wrPtr + 1'b1;
		end
		if (rdPtr == memEndAddr) begin
			rdPtrInc = memStartAddr;
		end else begin
			rdPtrInc = rdPtr + 1'b1;
		end
	end

	always_comb begin
		nextWrPtr = wrPtr;
		nextRdPtr = rdPtr;
		nextCmPtr = cmPtr;

		if (rdDone && memUsed != '0) begin
			nextRdPtr = rdPtrInc;
		end

		if (wrDone) begin
			nextWrPtr = wrPtrInc;
			if (!inTrans) begin
				nextCmPtr = wrPtrInc; // plain writes are visible at once.
			end
			if (wrPtrInc == rdPtr) begin
				nextRdPtr = rdPtrInc; // the buffer is full and drops its oldest word.
			end
		end

		if (rollback) begin
			nextWrPtr = nextCmPtr;
		end else if (commit) begin
			nextCmPtr = nextWrPtr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= memStartAddr;
			rdPtr <= memStartAddr;
			cmPtr <= memStartAddr;
			inTransFlag <= 1'b0;
			pushDone <= 1'b0;
			popDone <= 1'b0;
		end else begin
			wrPtr <= nextWrPtr;
			rdPtr <= nextRdPtr;
			cmPtr <= nextCmPtr;
			if (open) begin
				inTransFlag <= 1'b1;
			end else if (commit || rollback) begin
				inTransFlag <= 1'b0;
			end
			pushDone <= wrDone; // both done pulses lag the memory by one cycle.
			popDone <= rdDone;
		end
	end

endmodule

// File: hw/frameWriter.sv
module frameWriter (
	input  logic clk,
	input  logic rst,
	input  frameBufPkg::bufData inData,
	input  logic inValid,
	input  logic inLast,
	input  logic inError,
	output logic inReady,
	output logic pushRequest,
	output frameBufPkg::bufData pushData,
	input  logic pushDone,
	output logic open,
	output logic commit,
	output logic rollback
);
	import frameBufPkg::*;

	writerState state;
	writerState nextState;

	logic accept;
	logic lastWord;
	logic errSticky;
	logic inFrame;

	assign inReady = (state == wrIdle);
	assign accept = inValid && inReady;

	assign pushRequest = (state == wrPush);
	assign open = (state == wrPush) && !inFrame; // first word of a frame.
	assign commit = (state == wrClose) && !errSticky;
	assign rollback = (state == wrClose) && errSticky;

	always_comb begin
		nextState = state;
		case (state)
			wrIdle: begin
				if (accept) begin
					nextState = wrPush;
				end
			end
			wrPush: begin
				nextState = wrWait;
			end
			wrWait: begin
				if (pushDone) begin
					nextState = lastWord ? wrClose : wrIdle;
				end
			end
			wrClose: begin
				nextState = wrIdle;
			end
			default: begin
				nextState = wrIdle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= wrIdle;
			lastWord <= 1'b0;
			errSticky <= 1'b0;
			inFrame <= 1'b0;
		end else begin
			state <= nextState;
			if (accept) begin
				lastWord <= inLast;
				errSticky <= errSticky || inError; // any bad word spoils the frame.
			end
			if (state == wrPush) begin
				inFrame <= 1'b1;
			end
			if (state == wrClose) begin
				inFrame <= 1'b0;
				errSticky <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pushData <= inData;
		end
	end

endmodule

// File: hw/frameBufTop.sv
module frameBufTop (
	input  logic clk,
	input  logic rst,
	input  frameBufPkg::bufData inData,
	input  logic inValid,
	input  logic inLast,
	input  logic inError,
	output logic inReady,
	input  logic popReq,
	output frameBufPkg::bufData popData,
	output logic popDone,
	output frameBufPkg::bufCount memUsed
);
	import frameBufPkg::*;

	logic pushRequest;
	logic pushDone;
	bufData pushData;
	logic open;
	logic commit;
	logic rollback;

	logic wrRequest;
	logic wrDone;
	bufAddr wrAddr;
	bufData wrData;
	logic rdRequest;
	logic rdDone;
	bufAddr rdAddr;
	bufData rdData;

	frameWriter writer (
		.clk(clk),
		.rst(rst),
		.inData(inData),
		.inValid(inValid),
		.inLast(inLast),
		.inError(inError),
		.inReady(inReady),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.pushDone(pushDone),
		.open(open),
		.commit(commit),
		.rollback(rollback)
	);

	ringBuffer ring (
		.clk(clk),
		.rst(rst),
		.open(open),
		.commit(commit),
		.rollback(rollback),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.pushDone(pushDone),
		.popRequest(popReq),
		.popData(popData),
		.popDone(popDone),
		.memUsed(memUsed),
		.wrRequest(wrRequest),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrDone(wrDone),
		.rdRequest(rdRequest),
		.rdAddr(rdAddr),
		.rdDone(rdDone),
		.rdData(rdData)
	);

	bufferMemory memory (
		.clk(clk),
		.rst(rst),
		.wrRequest(wrRequest),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrDone(wrDone),
		.rdRequest(rdRequest),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.rdDone(rdDone)
	);

endmodule

// File: tb/frameBufTb.sv
module frameBufTb;
	import frameBufPkg::*;

	localparam int numRows = 10;
	localparam int capacity = bufDepth - 1;
	localparam logic [31:0] lfsrSeed = 32'h176fa8b7;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	logic clk;
	logic rst;
	bufData inData;
	logic inValid;
	logic inLast;
	logic inError;
	logic inReady;
	logic popReq;
	bufData popData;
	logic popDone;
	bufCount memUsed;

	string rowName [numRows];
	int rowFrames [numRows];
	logic [35:0] rowLens [numRows]; // frame lengths, one nibble per frame, frame 0 lowest.
	logic [8:0] rowErrs [numRows]; // bit f set means frame f ends with inError.
	int rowPops [numRows];

	bufData modelQ [$];
	bufData popped [$];
	logic [31:0] lfsrState;
	string curName;
	int rowErrors;
	int passedTests;
	int failedTests;
	int totalWords;
	int cycleCount;
	int cycleLimit = 100000;

	frameBufTop uut (
		.clk(clk),
		.rst(rst),
		.inData(inData),
		.inValid(inValid),
		.inLast(inLast),
		.inError(inError),
		.inReady(inReady),
		.popReq(popReq),
		.popData(popData),
		.popDone(popDone),
		.memUsed(memUsed)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the run did not finish", cycleCount);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ lfsrTaps;
		end else begin
			return state >> 1;
		end
	endfunction

	task automatic drawWord(output bufData word);
		int b;
		for (b = 0; b < dataWidth; b++) begin
			word[b] = lfsrState[0]; // one step per bit taken.
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	task automatic setRow(input int idx, input string name, input int frames,
			input logic [35:0] lens, input logic [8:0] errs, input int pops);
		rowName[idx] = name;
		rowFrames[idx] = frames;
		rowLens[idx] = lens;
		rowErrs[idx] = errs;
		rowPops[idx] = pops;
	endtask

	task automatic buildTable();
		setRow(0, "reset empty", 0, 36'h0, 9'b0, 1);
		setRow(1, "commit three", 1, 36'h3, 9'b0, 3);
		setRow(2, "rollback error", 3, 36'h232, 9'b010, 4);
		setRow(3, "hidden long frame", 2, 36'h61, 9'b0, 7);
		setRow(4, "overwrite nine", 9, 36'h111111111, 9'b0, 7);
		setRow(5, "wrap a", 3, 36'h223, 9'b010, 3);
		setRow(6, "wrap b", 3, 36'h314, 9'b010, 5);
		setRow(7, "wrap c", 3, 36'h252, 9'b001, 6);
		setRow(8, "wrap d", 3, 36'h433, 9'b010, 9); // asks for more pops than stored.
		setRow(9, "wrap e", 4, 36'h2115, 9'b0010, 4);
	endtask

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", curName, what,
				expected, actual);
			rowErrors++;
		end
	endtask

	task automatic sendFrame(input int len, input logic err);
		bufData word;
		bufData words [$];
		bit fits;
		int k;
		int waitCycles;
		fits = (modelQ.size() + len <= capacity); // no old word is dropped while writing.
		for (k = 0; k < len; k++) begin
			drawWord(word);
			words.push_back(word);
			waitCycles = 0;
			while (!inReady && waitCycles < 20) begin
				@(negedge clk);
				waitCycles++;
			end
			assert (inReady) else begin
				$display("%s: inReady stayed low for 20 cycles, the writer took no word",
					curName);
				rowErrors++;
			end
			// uncommitted words must not show in the used level.
			if (fits) begin
				checkValue("memUsed during frame", modelQ.size(), int'(memUsed));
			end
			inData = word;
			inValid = 1'b1;
			inLast = (k == len - 1);
			inError = err && (k == len - 1);
			@(negedge clk);
			inValid = 1'b0;
			inLast = 1'b0;
			inError = 1'b0;
		end
		if (!err) begin
			foreach (words[i]) begin
				modelQ.push_back(words[i]);
			end
			while (modelQ.size() > capacity) begin
				void'(modelQ.pop_front()); // the oldest word is overwritten.
			end
		end
	endtask

	task automatic waitStable();
		int stable;
		bufCount prev;
		stable = 0;
		prev = memUsed;
		while (stable < 4) begin
			@(negedge clk);
			if (inReady && memUsed == prev) begin
				stable++;
			end else begin
				stable = 0;
			end
			prev = memUsed;
		end
	endtask

	task automatic runRow(input int r);
		int f;
		int expectedPops;
		int got;
		int idle;
		int h;
		bufData expWord;
		curName = rowName[r];
		rowErrors = 0;
		if (r == 0) begin
			checkValue("memUsed after reset", 0, int'(memUsed));
			checkValue("popDone after reset", 0, int'(popDone));
			checkValue("inReady after reset", 1, int'(inReady));
		end
		for (f = 0; f < rowFrames[r]; f++) begin
			sendFrame(int'(rowLens[r][f*4 +: 4]), rowErrs[r][f]);
		end
		waitStable();
		checkValue("memUsed after frames", modelQ.size(), int'(memUsed));

		expectedPops = (rowPops[r] < modelQ.size()) ? rowPops[r] : modelQ.size();
		popped.delete();
		got = 0;
		idle = 0;
		popReq = 1'b1;
		while (got < expectedPops && idle < 20) begin
			@(negedge clk);
			if (popDone) begin
				popped.push_back(popData);
				got++;
				idle = 0;
				if (got == rowPops[r]) begin
					popReq = 1'b0; // dropped before the next read can start.
				end
			end else begin
				idle++;
			end
		end
		assert (got == expectedPops) else begin
			$display("%s: popDone did not arrive within 20 cycles, %0d of %0d words read",
				curName, got, expectedPops);
			rowErrors++;
		end
		// Reads past the last committed word must be ignored.
		if (rowPops[r] > expectedPops) begin
			for (h = 0; h < 8; h++) begin
				@(negedge clk);
				assert (!popDone) else begin
					$display("%s: popDone pulsed although the buffer was empty", curName);
					rowErrors++;
				end
			end
		end
		popReq = 1'b0;

		for (h = 0; h < expectedPops; h++) begin
			expWord = modelQ.pop_front();
			if (h < popped.size()) begin
				checkValue($sformatf("popped word %0d", h), expWord, popped[h]);
			end
		end
		@(negedge clk);
		checkValue("memUsed after pops", modelQ.size(), int'(memUsed));

		if (rowErrors == 0) begin
			$display("test %s: passed", curName);
			passedTests++;
		end else begin
			$display("test %s: failed with %0d errors", curName, rowErrors);
			failedTests++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inData = '0;
		inValid = 1'b0;
		inLast = 1'b0;
		inError = 1'b0;
		popReq = 1'b0;
		lfsrState = lfsrSeed;
		cycleCount = 0;
		passedTests = 0;
		failedTests = 0;
		buildTable();
		totalWords = 0;
		for (int r = 0; r < numRows; r++) begin
			for (int f = 0; f < rowFrames[r]; f++) begin
				totalWords += int'(rowLens[r][f*4 +: 4]);
			end
		end
		cycleLimit = totalWords * 20 + 500;

		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		for (int r = 0; r < numRows; r++) begin
			runRow(r);
		end

		$display("summary: %0d tests passed, %0d tests failed", passedTests, failedTests);
		if (failedTests == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
hw/frameBufPkg.sv
hw/bufferMemory.sv
hw/ringBuffer.sv
hw/frameWriter.sv
hw/frameBufTop.sv
tb/frameBufTb.sv

// File: Bender.yml
package:
  name: frame_buf

sources:
  - files:
      - hw/frameBufPkg.sv
      - hw/bufferMemory.sv
      - hw/ringBuffer.sv
      - hw/frameWriter.sv
      - hw/frameBufTop.sv
  - target: simulation
    files:
      - tb/frameBufTb.sv
